//--- run.sh
#!/bin/sh
# Build the offload testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f xif_offload_top.f --top-module xif_offload_tb -o xif_offload_sim

sim_out=$(./obj_dir/xif_offload_sim 2>&1 || true)
printf '%s\n' "$sim_out"

# Exit status follows the search for the pass line
printf '%s\n' "$sim_out" | grep -qx "TEST PASSED"

//--- src/simd_byte_unit.sv
// Two-stage stallable packed-byte SIMD unit on 32-bit words
`timescale 1ns/1ps

module simd_byte_unit
  import xif_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,

  // Request
  input  logic       req_valid_i,
  input  xif_c_req_t req_i,
  output logic       req_ready_o,

  // Result
  output logic       rsp_valid_o,
  output xif_c_rsp_t rsp_o,
  input  logic       rsp_ready_i
);

  // Stage 1 contents, one 16-bit result per byte lane
  typedef struct packed {
    xif_op_e          op;
    logic [4:0]       rd;
    logic [3:0][15:0] lane;
  } stage1_t;

  logic [3:0][7:0] a_bytes;
  logic [3:0][7:0] b_bytes;

  logic            s1_valid_q;
  logic            s1_ready;
  stage1_t         s1_d;
  stage1_t         s1_q;

  logic            s2_valid_q;
  logic            s2_ready;
  logic [31:0]     lane_sum;
  logic [31:0]     s2_data;
  xif_c_rsp_t      s2_q;

  assign a_bytes = req_i.rs1;
  assign b_bytes = req_i.rs2;

  // A stage moves when the next one is empty or moving
  assign s2_ready    = ~s2_valid_q | rsp_ready_i;
  assign s1_ready    = ~s1_valid_q | s2_ready;
  assign req_ready_o = s1_ready;

  // Per-lane operation
  always_comb begin
    s1_d.op = req_i.op;
    s1_d.rd = req_i.rd;
    for (int i = 0; i < 4; i++) begin
      case (req_i.op)
        OP_ADD8:  s1_d.lane[i] = {8'h00, a_bytes[i] + b_bytes[i]};
        OP_SUB8:  s1_d.lane[i] = {8'h00, a_bytes[i] - b_bytes[i]};
        OP_MINU8: s1_d.lane[i] = {8'h00, (a_bytes[i] < b_bytes[i]) ? a_bytes[i] : b_bytes[i]};
        OP_MAXU8: s1_d.lane[i] = {8'h00, (a_bytes[i] > b_bytes[i]) ? a_bytes[i] : b_bytes[i]};
        OP_DOTP8: s1_d.lane[i] = 16'(a_bytes[i]) * 16'(b_bytes[i]);
        OP_SAD8: begin
          if (a_bytes[i] > b_bytes[i]) begin
            s1_d.lane[i] = {8'h00, a_bytes[i] - b_bytes[i]};
          end else begin
            s1_d.lane[i] = {8'h00, b_bytes[i] - a_bytes[i]};
          end
        end
        default:  s1_d.lane[i] = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      s1_valid_q <= 1'b0;
    end else if (s1_ready) begin
      s1_valid_q <= req_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (s1_ready && req_valid_i) begin
      s1_q <= s1_d;
    end
  end

  // Reduction across lanes, upper lane bits are zero for SAD8
  assign lane_sum = 32'(s1_q.lane[0]) + 32'(s1_q.lane[1]) +
                    32'(s1_q.lane[2]) + 32'(s1_q.lane[3]);

  // Stage 2 packs or reduces
  always_comb begin
    case (s1_q.op)
      OP_DOTP8, OP_SAD8: s2_data = lane_sum;
      default: begin
        s2_data = {s1_q.lane[3][7:0], s1_q.lane[2][7:0],
                   s1_q.lane[1][7:0], s1_q.lane[0][7:0]};
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      s2_valid_q <= 1'b0;
    end else if (s2_ready) begin
      s2_valid_q <= s1_valid_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (s2_ready && s1_valid_q) begin
      s2_q.rd   <= s1_q.rd;
      s2_q.data <= s2_data;
    end
  end

  assign rsp_valid_o = s2_valid_q;
  assign rsp_o       = s2_q;

endmodule

//--- src/xif_adapter.sv
// Adapter from the flat X channels to the internal C channel with a registered response slice
`timescale 1ns/1ps

module xif_adapter
  import xif_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_n_i,

  // X-request and accept sideband
  input  logic             x_q_valid_i,
  input  logic [31:0]      x_q_instr_i,
  input  logic [1:0][31:0] x_q_rs_i,
  input  logic [1:0]       x_q_rs_valid_i,
  output logic             x_q_ready_o,
  output logic             x_k_accept_o,
  output logic             x_k_writeback_o,

  // Predecoder
  output logic [31:0]      prd_instr_o,
  input  xif_prd_rsp_t     prd_i,

  // C-request towards the accelerator
  output logic             c_req_valid_o,
  output xif_c_req_t       c_req_o,
  input  logic             c_req_ready_i,

  // C-response from the accelerator
  input  logic             c_rsp_valid_i,
  input  xif_c_rsp_t       c_rsp_i,
  output logic             c_rsp_ready_o,

  // X-response
  output logic             x_p_valid_o,
  output xif_c_rsp_t       x_p_o,
  input  logic             x_p_ready_i
);

  logic       operands_ok;
  logic       rsp_valid_q;
  xif_c_rsp_t rsp_q;

  assign prd_instr_o = x_q_instr_i;

  // rs1 always needed, rs2 only when the predecoder asks for it
  assign operands_ok = x_q_rs_valid_i[0] & (x_q_rs_valid_i[1] | ~prd_i.use_rs2);

  // Every accepted operation writes rd
  assign x_k_accept_o    = prd_i.accept;
  assign x_k_writeback_o = prd_i.accept;

  // Accepted requests wait for operands and a free accelerator
  assign c_req_valid_o = x_q_valid_i & prd_i.accept & operands_ok;

  // Rejected requests are acknowledged at once
  assign x_q_ready_o = x_q_valid_i & (~prd_i.accept | (operands_ok & c_req_ready_i));

  always_comb begin
    c_req_o.op  = prd_i.op;
    c_req_o.rs1 = x_q_rs_i[0];
    c_req_o.rs2 = prd_i.use_rs2 ? x_q_rs_i[1] : '0;
    c_req_o.rd  = x_q_instr_i[11:7];
  end

  // One-entry response register, refilled while it drains
  assign c_rsp_ready_o = ~rsp_valid_q | x_p_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else if (c_rsp_ready_o) begin
      rsp_valid_q <= c_rsp_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (c_rsp_valid_i && c_rsp_ready_o) begin
      rsp_q <= c_rsp_i;
    end
  end

  assign x_p_valid_o = rsp_valid_q;
  assign x_p_o       = rsp_q;

endmodule

//--- src/xif_offload_top.sv
// Offload subsystem top with flat X-interface ports around adapter, predecoder and SIMD unit
`timescale 1ns/1ps

module xif_offload_top
  import xif_pkg::*;
#(
  parameter logic [6:0] CustomOpcode = OPCODE_CUSTOM0
) (
  input  logic             clk_i,
  input  logic             rst_n_i,

  // X-request channel
  input  logic             x_q_valid_i,
  output logic             x_q_ready_o,
  input  logic [31:0]      x_q_instr_data_i,
  input  logic [1:0][31:0] x_q_rs_i,
  input  logic [1:0]       x_q_rs_valid_i,
  output logic             x_k_accept_o,
  output logic             x_k_writeback_o,

  // X-response channel
  output logic             x_p_valid_o,
  input  logic             x_p_ready_i,
  output logic [4:0]       x_p_rd_o,
  output logic [31:0]      x_p_data_o
);

  logic [31:0]  prd_instr;
  xif_prd_rsp_t prd_rsp;

  logic         c_q_valid;
  logic         c_q_ready;
  xif_c_req_t   c_req;

  logic         c_p_valid;
  logic         c_p_ready;
  xif_c_rsp_t   c_rsp;

  xif_c_rsp_t   x_rsp;

  // X-response struct onto flat ports
  assign x_p_rd_o   = x_rsp.rd;
  assign x_p_data_o = x_rsp.data;

  xif_adapter u_adapter (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .x_q_valid_i    (x_q_valid_i),
    .x_q_instr_i    (x_q_instr_data_i),
    .x_q_rs_i       (x_q_rs_i),
    .x_q_rs_valid_i (x_q_rs_valid_i),
    .x_q_ready_o    (x_q_ready_o),
    .x_k_accept_o   (x_k_accept_o),
    .x_k_writeback_o(x_k_writeback_o),
    .prd_instr_o    (prd_instr),
    .prd_i          (prd_rsp),
    .c_req_valid_o  (c_q_valid),
    .c_req_o        (c_req),
    .c_req_ready_i  (c_q_ready),
    .c_rsp_valid_i  (c_p_valid),
    .c_rsp_i        (c_rsp),
    .c_rsp_ready_o  (c_p_ready),
    .x_p_valid_o    (x_p_valid_o),
    .x_p_o          (x_rsp),
    .x_p_ready_i    (x_p_ready_i)
  );

  xif_predecoder #(
    .CustomOpcode(CustomOpcode)
  ) u_predecoder (
    .instr_i(prd_instr),
    .prd_o  (prd_rsp)
  );

  simd_byte_unit u_simd (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_valid_i(c_q_valid),
    .req_i      (c_req),
    .req_ready_o(c_q_ready),
    .rsp_valid_o(c_p_valid),
    .rsp_o      (c_rsp),
    .rsp_ready_i(c_p_ready)
  );

endmodule

//--- src/xif_pkg.sv
// Shared operation, request and response types for the X-interface SIMD offload
package xif_pkg;

  // Major opcode of the custom-0 space, the default offload opcode
  // Custom-1 (7'b0101011) works the same when passed as the top parameter
  localparam logic [6:0] OPCODE_CUSTOM0 = 7'b0001011;

  // Only funct7 value that selects the packed-byte unit
  localparam logic [6:0] FUNCT7_SIMD = 7'b0000000;

  // Highest funct3 value that maps onto an operation
  localparam logic [2:0] FUNCT3_LAST = 3'b101;

  // Accelerator operation, encoded as funct3 of the instruction
  typedef enum logic [2:0] {
    OP_ADD8  = 3'b000,
    OP_SUB8  = 3'b001,
    OP_MINU8 = 3'b010,
    OP_MAXU8 = 3'b011,
    OP_DOTP8 = 3'b100,
    OP_SAD8  = 3'b101
  } xif_op_e;

  // Predecoder answer for one instruction word
  typedef struct packed {
    logic    accept;
    xif_op_e op;
    // Second source operand needed before issue
    logic    use_rs2;
  } xif_prd_rsp_t;

  // Internal request from the adapter to the accelerator, 72 bits
  typedef struct packed {
    xif_op_e     op;
    logic [31:0] rs1;
    logic [31:0] rs2;
    logic [4:0]  rd;
  } xif_c_req_t;

  // Result of the accelerator, also used for the X-response
  typedef struct packed {
    logic [4:0]  rd;
    logic [31:0] data;
  } xif_c_rsp_t;

endpackage

//--- src/xif_predecoder.sv
// Combinational predecoder deciding acceptance and operation of an instruction word
`timescale 1ns/1ps

module xif_predecoder
  import xif_pkg::*;
#(
  parameter logic [6:0] CustomOpcode = OPCODE_CUSTOM0
) (
  input  logic [31:0]  instr_i,
  output xif_prd_rsp_t prd_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       match;
  xif_op_e    op;

  // R-type fields
  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  assign match = (opcode == CustomOpcode) &&
                 (funct7 == FUNCT7_SIMD) &&
                 (funct3 <= FUNCT3_LAST);

  always_comb begin
    op            = OP_ADD8;
    prd_o.accept  = match;
    prd_o.use_rs2 = 1'b0;
    if (match) begin
      op = xif_op_e'(funct3);
      // Source needs per operation, all current ones are two-source
      case (op)
        OP_ADD8, OP_SUB8:   prd_o.use_rs2 = 1'b1;
        OP_MINU8, OP_MAXU8: prd_o.use_rs2 = 1'b1;
        OP_DOTP8, OP_SAD8:  prd_o.use_rs2 = 1'b1;
        default:            prd_o.use_rs2 = 1'b0;
      endcase
    end
    prd_o.op = op;
  end

endmodule

//--- test/xif_offload_chk.sv
// Bound checker with concurrent handshake assertions on the X-interface ports of the offload top
`timescale 1ns/1ps

module xif_offload_chk
  import xif_pkg::*;
#(
  parameter logic [6:0] CustomOpcode = OPCODE_CUSTOM0
) (
  input logic        clk_i,
  input logic        rst_n_i,
  input logic        q_valid_i,
  input logic        q_ready_i,
  input logic [31:0] q_instr_i,
  input logic        k_accept_i,
  input logic        p_valid_i,
  input logic        p_ready_i,
  input logic [4:0]  p_rd_i,
  input logic [31:0] p_data_i
);

  // Number of failed assertions
  int fail_cnt = 0;

  // Request valid and instruction held until the handshake
  req_hold: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    q_valid_i && !q_ready_i |=> q_valid_i && $stable(q_instr_i)
  ) else begin
    fail_cnt++;
    $error("request valid dropped or instruction changed before ready");
  end

  // Response valid, rd and data held until the handshake
  rsp_hold: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    p_valid_i && !p_ready_i |=> p_valid_i && $stable({p_rd_i, p_data_i})
  ) else begin
    fail_cnt++;
    $error("response valid dropped or payload changed before ready");
  end

  rsp_valid_known: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !$isunknown(p_valid_i)
  ) else begin
    fail_cnt++;
    $error("response valid is unknown");
  end

  // Only the configured major opcode can be accepted
  accept_opcode: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    k_accept_i |-> q_instr_i[6:0] == CustomOpcode
  ) else begin
    fail_cnt++;
    $error("instruction accepted with a foreign opcode");
  end

  reset_quiet: assert property (
    @(posedge clk_i) $rose(rst_n_i) |-> !p_valid_i && !q_ready_i
  ) else begin
    fail_cnt++;
    $error("output valid high in the first cycle after reset");
  end

endmodule

//--- test/xif_offload_tb.sv
// Testbench driving random offload instructions and checking results against a byte-lane model
`timescale 1ns/1ps

module xif_offload_tb
  import xif_pkg::*;
();

  localparam logic [6:0] TB_OPCODE = 7'b0001011;
  localparam int SEED = 4662;
  localparam int N_RAND = 48;
  localparam int N_REJ = 12;
  localparam int N_WAIT = 12;
  localparam int N_BP = 60;
  localparam int N_B2B = 24;
  localparam int N_TOTAL = N_RAND + N_REJ + N_WAIT + N_BP + N_B2B;
  localparam int CYCLE_LIMIT = 40 * N_TOTAL + 200;

  // Expected response of one accepted instruction
  typedef struct packed {
    logic [4:0]  rd;
    logic [31:0] data;
    logic        timed;
    int          cycle;
  } exp_rsp_t;

  logic             clk_i = 1'b0;
  logic             rst_n_i;
  logic             x_q_valid_i;
  logic             x_q_ready_o;
  logic [31:0]      x_q_instr_data_i;
  logic [1:0][31:0] x_q_rs_i;
  logic [1:0]       x_q_rs_valid_i;
  logic             x_k_accept_o;
  logic             x_k_writeback_o;
  logic             x_p_valid_o;
  logic             x_p_ready_i;
  logic [4:0]       x_p_rd_o;
  logic [31:0]      x_p_data_o;

  integer           seed = SEED;
  int               cycle_cnt = 0;
  int               check_cnt = 0;
  int               mismatch_cnt = 0;
  int               other_cnt = 0;
  int               low_left = 0;
  logic             ready_random = 1'b0;
  logic [6:0]       opcode;
  exp_rsp_t         exp_q[$];

  xif_offload_top #(
    .CustomOpcode(TB_OPCODE)
  ) u_dut (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .x_q_valid_i     (x_q_valid_i),
    .x_q_ready_o     (x_q_ready_o),
    .x_q_instr_data_i(x_q_instr_data_i),
    .x_q_rs_i        (x_q_rs_i),
    .x_q_rs_valid_i  (x_q_rs_valid_i),
    .x_k_accept_o    (x_k_accept_o),
    .x_k_writeback_o (x_k_writeback_o),
    .x_p_valid_o     (x_p_valid_o),
    .x_p_ready_i     (x_p_ready_i),
    .x_p_rd_o        (x_p_rd_o),
    .x_p_data_o      (x_p_data_o)
  );

  bind xif_offload_top xif_offload_chk #(
    .CustomOpcode(CustomOpcode)
  ) u_chk (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .q_valid_i (x_q_valid_i),
    .q_ready_i (x_q_ready_o),
    .q_instr_i (x_q_instr_data_i),
    .k_accept_i(x_k_accept_o),
    .p_valid_i (x_p_valid_o),
    .p_ready_i (x_p_ready_i),
    .p_rd_i    (x_p_rd_o),
    .p_data_i  (x_p_data_o)
  );

  always #4 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == CYCLE_LIMIT) begin
      $display("Timeout at %0t: run timed out waiting for responses", $time);
      finish_run(1'b1);
    end
  end

  function automatic logic [31:0] next_rand();
    return $random(seed);
  endfunction

  // Byte-lane results as defined for each funct3 operation
  function automatic logic [31:0] simd_model(input logic [2:0] funct3, input logic [31:0] a,
                                             input logic [31:0] b);
    logic [31:0] res;
    int          x;
    int          y;
    int          acc;
    res = '0;
    acc = 0;
    for (int i = 0; i < 4; i++) begin
      x = int'(a[8*i +: 8]);
      y = int'(b[8*i +: 8]);
      case (xif_op_e'(funct3))
        OP_ADD8:  res[8*i +: 8] = 8'(x + y);
        OP_SUB8:  res[8*i +: 8] = 8'(x - y);
        OP_MINU8: res[8*i +: 8] = 8'((x < y) ? x : y);
        OP_MAXU8: res[8*i +: 8] = 8'((x > y) ? x : y);
        OP_DOTP8: acc = acc + x * y;
        default:  acc = acc + ((x > y) ? x - y : y - x);
      endcase
    end
    if (funct3 == 3'd4 || funct3 == 3'd5) begin
      res = 32'(acc);
    end
    return res;
  endfunction

  function automatic logic accept_model(input logic [31:0] instr);
    return (instr[6:0] == opcode) && (instr[31:25] == 7'b0000000) && (instr[14:12] < 3'd6);
  endfunction

  function automatic logic [31:0] make_instr(input logic [6:0] funct7, input logic [2:0] funct3,
                                             input logic [4:0] rd, input logic [6:0] opc);
    logic [31:0] r;
    r = next_rand();
    return {funct7, r[24:20], r[19:15], funct3, rd, opc};
  endfunction

  task automatic finish_run(input logic timed_out);
    int fails;
    fails = mismatch_cnt + other_cnt + u_dut.u_chk.fail_cnt;
    if (timed_out) begin
      fails++;
    end
    $display("Checks: %0d, mismatches: %0d, other errors: %0d, assertions: %0d, timeouts: %0d",
             check_cnt, mismatch_cnt, other_cnt, u_dut.u_chk.fail_cnt, timed_out);
    if (fails == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  task automatic check_response();
    exp_rsp_t want;
    check_cnt++;
    if (exp_q.size() == 0) begin
      $display("Error at %0t: response for rd %0d with no instruction outstanding", $time, x_p_rd_o);
      other_cnt++;
    end else begin
      want = exp_q.pop_front();
      if (x_p_rd_o !== want.rd || x_p_data_o !== want.data) begin
        $display("Mismatch at %0t: rd %0d data %08h, expected rd %0d data %08h",
                 $time, x_p_rd_o, x_p_data_o, want.rd, want.data);
        mismatch_cnt++;
      end
      if (want.timed && cycle_cnt - want.cycle != 3) begin
        $display("Mismatch at %0t: response after %0d cycles, expected 3",
                 $time, cycle_cnt - want.cycle);
        mismatch_cnt++;
      end
    end
  endtask

  // Falling edge, request dropped and response ready chosen
  task automatic next_cycle();
    logic [31:0] r;
    @(negedge clk_i);
    r = next_rand();
    x_q_valid_i    = 1'b0;
    x_q_rs_valid_i = 2'b00;
    if (!ready_random) begin
      x_p_ready_i = 1'b1;
    end else if (low_left > 0) begin
      x_p_ready_i = 1'b0;
      low_left--;
    end else if (r[2:0] == 3'b000) begin
      x_p_ready_i = 1'b0;
      low_left = int'(r[5:4]);
    end else begin
      x_p_ready_i = 1'b1;
    end
  endtask

  // Outputs settle well before the next rising edge
  task automatic sample();
    #3;
    if (x_p_valid_o && x_p_ready_i) begin
      check_response();
    end
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) begin
      next_cycle();
      sample();
    end
  endtask

  task automatic drain();
    ready_random = 1'b0;
    while (exp_q.size() != 0) begin
      idle(1);
    end
    idle(4);
  endtask

  task automatic issue(input logic [31:0] instr, input logic [31:0] rs1, input logic [31:0] rs2,
                       input int rs_delay, input logic timed);
    logic     accept_exp;
    logic     done;
    int       waited;
    exp_rsp_t entry;
    accept_exp = accept_model(instr);
    done = 1'b0;
    waited = 0;
    while (!done) begin
      next_cycle();
      x_q_valid_i      = 1'b1;
      x_q_instr_data_i = instr;
      if (waited < rs_delay) begin
        // Neither, only rs1 or only rs2 valid while waiting
        x_q_rs_valid_i = 2'(waited % 3);
        x_q_rs_i[0]    = next_rand();
        x_q_rs_i[1]    = next_rand();
      end else begin
        x_q_rs_valid_i = 2'b11;
        x_q_rs_i[0]    = rs1;
        x_q_rs_i[1]    = rs2;
      end
      sample();
      if (x_q_ready_o) begin
        done = 1'b1;
        check_cnt++;
        if (waited < rs_delay) begin
          $display("Error at %0t: request taken before its operands were valid", $time);
          other_cnt++;
        end
        if (x_k_accept_o !== accept_exp || x_k_writeback_o !== accept_exp) begin
          $display("Mismatch at %0t: instr %08h accept %b writeback %b, expected %b",
                   $time, instr, x_k_accept_o, x_k_writeback_o, accept_exp);
          mismatch_cnt++;
        end
        if (accept_exp) begin
          entry.rd    = instr[11:7];
          entry.data  = simd_model(instr[14:12], rs1, rs2);
          entry.timed = timed;
          entry.cycle = cycle_cnt;
          exp_q.push_back(entry);
        end
      end else if (!accept_exp) begin
        $display("Error at %0t: rejected instruction %08h not acknowledged at once", $time, instr);
        other_cnt++;
      end
      waited++;
    end
  endtask

  task automatic issue_op(input logic [2:0] funct3, input int rs_delay, input logic timed);
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] b;
    r = next_rand();
    a = next_rand();
    b = next_rand();
    issue(make_instr(FUNCT7_SIMD, funct3, r[4:0], opcode), a, b, rs_delay, timed);
  endtask

  // Wrong opcode, nonzero funct7, or funct3 beyond the last operation
  task automatic issue_reject(input int kind);
    logic [31:0] r;
    logic [31:0] instr;
    r = next_rand();
    if (kind == 0) begin
      instr = make_instr(7'b0000000, r[10:8] % 3'd6, r[15:11], opcode ^ (r[6:0] | 7'h01));
    end else if (kind == 1) begin
      instr = make_instr(r[31:25] | 7'h40, r[10:8] % 3'd6, r[15:11], opcode);
    end else begin
      instr = make_instr(7'b0000000, {2'b11, r[0]}, r[15:11], opcode);
    end
    issue(instr, next_rand(), next_rand(), 0, 1'b0);
  endtask

  initial begin
    logic [31:0] r;
    rst_n_i          = 1'b0;
    x_q_valid_i      = 1'b0;
    x_q_instr_data_i = '0;
    x_q_rs_i         = '0;
    x_q_rs_valid_i   = 2'b00;
    x_p_ready_i      = 1'b0;
    opcode           = u_dut.CustomOpcode;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    idle(2);

    // All six operations on random operands
    for (int i = 0; i < N_RAND; i++) begin
      r = next_rand();
      issue_op(3'(i % 6), 0, 1'b0);
      idle(int'(r[1:0]) % 3);
    end
    drain();

    for (int i = 0; i < N_REJ; i++) begin
      issue_reject(i % 3);
    end
    drain();

    // Operands arrive late
    for (int i = 0; i < N_WAIT; i++) begin
      r = next_rand();
      issue_op(3'(i % 6), 1 + int'(r[1:0]), 1'b0);
    end
    drain();

    // Response back-pressure with rejected instructions mixed in
    ready_random = 1'b1;
    for (int i = 0; i < N_BP; i++) begin
      r = next_rand();
      if (i % 6 == 5) begin
        issue_reject(i % 3);
      end else begin
        issue_op(3'($unsigned(r) % 6), 0, 1'b0);
      end
    end
    drain();

    // Back-to-back issue with fixed latency
    for (int i = 0; i < N_B2B; i++) begin
      r = next_rand();
      issue_op(3'($unsigned(r) % 6), 0, 1'b1);
    end
    drain();

    finish_run(1'b0);
  end

endmodule

//--- xif_offload_top.f
src/xif_pkg.sv
src/xif_predecoder.sv
src/xif_adapter.sv
src/simd_byte_unit.sv
src/xif_offload_top.sv
test/xif_offload_chk.sv
test/xif_offload_tb.sv
